/* build.f */
src/arcade_input_pkg.sv
src/clk_enable_gen.sv
src/ps2_button_decoder.sv
src/loader_capture.sv
src/cabinet_input_map.sv
src/arcade_input_top.sv
verif/tb_arcade_input.sv

/* verif/tb_arcade_input.sv */
/*
 * Arcade input testbench
 * Table-driven checks of the clock enables, keyboard decode, loader
 * capture, ROM strobe and the per-game port mapping
 */
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_input;

	import arcade_input_pkg::*;

	localparam int CLK_PERIOD      = 40;
	localparam int N_ENTRIES       = 14;
	localparam int WATCHDOG_CYCLES = N_ENTRIES * 8 + 200;

	typedef struct
	{
		logic [7:0]  game;
		logic        fire_mode;
		logic [10:0] joy1;
		logic [10:0] joy2;
		port_bytes_t ports;
		game_cfg_t   cfg;
	} map_entry_t;

	logic          clk_sys = 1'b0;
	logic          arst_n;
	ps2_key_t      key;
	joy_t          joy1;
	joy_t          joy2;
	loader_wr_t    ldr;
	logic          fire_mode;
	clk_en_t       ce;
	port_bytes_t   ports;
	game_cfg_t     cfg;
	logic          rom_wr;
	logic [15:0]   rom_addr;
	logic [7:0]    rom_data;

	map_entry_t tbl [N_ENTRIES];
	int         n_loaded = 0;
	int         n12;
	int         n6p;
	int         n6n;
	int         n1p79;

	arcade_input_top u_arcade_input_top (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.key       (key),
		.joy1      (joy1),
		.joy2      (joy2),
		.ldr       (ldr),
		.fire_mode (fire_mode),
		.ce        (ce),
		.ports     (ports),
		.cfg       (cfg),
		.rom_wr    (rom_wr),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ====================
	// Helpers
	// ====================

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("ERROR: %s = 0x%0h, expected 0x%0h", name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic add_entry(input logic [7:0] game, input logic fm,
		input logic [10:0] j1, input logic [10:0] j2, input logic [31:0] exp_ports,
		input hw_board_e board, input logic fourfire, input logic gal_video);
		tbl[n_loaded].game      = game;
		tbl[n_loaded].fire_mode = fm;
		tbl[n_loaded].joy1      = j1;
		tbl[n_loaded].joy2      = j2;
		tbl[n_loaded].ports     = exp_ports;
		tbl[n_loaded].cfg       = '{board, 1'b0, fourfire, gal_video};
		n_loaded++;
	endtask

	// One loader write, returns on the falling edge after it was taken
	task automatic loader_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(negedge clk_sys);
		ldr = '{wr: 1'b1, index: index, addr: addr, data: data};
		@(negedge clk_sys);
		ldr.wr = 1'b0;
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		@(negedge clk_sys);
		key.toggle  = ~key.toggle;  // New event
		key.pressed = pressed;
		key.code    = code;
	endtask

	task automatic check_game_cfg(input logic [7:0] game, input hw_board_e board,
		input logic fourfire, input logic gal_video);
		loader_write(IDX_GAME, 25'd0, game);
		check_value("cfg", cfg, {board, 1'b0, fourfire, gal_video});
	endtask

	task automatic check_ports(input port_bytes_t expected);
		check_value("ports.pa", ports.pa, expected.pa);
		check_value("ports.pb", ports.pb, expected.pb);
		check_value("ports.pc", ports.pc, expected.pc);
		check_value("ports.pd", ports.pd, expected.pd);
	endtask

	// ====================
	// Watchdog
	// ====================

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: the test sequence did not finish in time");
		$display(">>> FAIL");
		$fatal(1, "Watchdog expired");
	end

	// ====================
	// Stimulus
	// ====================

	initial
	begin
		void'($urandom(32'hda6f_4850));
		arst_n    = 1'b0;
		key       = '0;
		joy1      = {5'($urandom), 11'h000};  // Idle noise on unused bits
		joy2      = {5'($urandom), 11'h000};
		ldr       = '0;
		fire_mode = 1'b0;

		// Expected port bytes are pa, pb, pc, pd from left to right
		add_entry(scramble, 0, 11'h000, 11'h000, 32'hFFFF_FFFF, hw_scramble, 0, 0);
		add_entry(scramble, 0, 11'h018, 11'h000, 32'hF6F7_EFFF, hw_scramble, 0, 0);
		add_entry(frogger,  0, 11'h000, 11'h406, 32'h5FDF_BEFF, hw_frogger,  0, 0);
		add_entry(theend,   0, 11'h121, 11'h200, 32'hED2B_FFFF, hw_scramble, 0, 1);
		add_entry(tazman,   0, 11'h024, 11'h100, 32'hF6FF_FEFF, hw_scobra,   0, 0);
		add_entry(tazman,   0, 11'h011, 11'h600, 32'h6DFF_BFFF, hw_scobra,   0, 0);
		add_entry(calipso,  0, 11'h008, 11'h200, 32'hFAFB_FFFF, hw_calipso,  0, 0);
		add_entry(calipso,  0, 11'h012, 11'h000, 32'hDEDF_FEFF, hw_calipso,  0, 0);
		add_entry(losttomb, 1, 11'h101, 11'h000, 32'hEDAF_FFFF, hw_losttomb, 1, 0);
		add_entry(losttomb, 0, 11'h0C0, 11'h228, 32'hFAD3_FFFF, hw_losttomb, 1, 0);
		add_entry(losttomb, 1, 11'h0C0, 11'h228, 32'hFAFB_FFFF, hw_losttomb, 1, 0);
		add_entry(minefld,  1, 11'h016, 11'h500, 32'h56D7_FEFF, hw_losttomb, 1, 0);
		add_entry(minefld,  0, 11'h016, 11'h500, 32'h56EF_FEFF, hw_losttomb, 1, 0);
		add_entry(8'd5,     0, 11'h018, 11'h000, 32'hF6F7_EFFF, hw_scramble, 0, 0);  // Unknown

		repeat (3) @(negedge clk_sys);
		arst_n = 1'b1;

		// Clock enables over one full slow period multiple
		n12   = 0;
		n6p   = 0;
		n6n   = 0;
		n1p79 = 0;
		repeat (56)
		begin
			@(negedge clk_sys);
			n12   += ce.ce_12;
			n6p   += ce.ce_6p;
			n6n   += ce.ce_6n;
			n1p79 += ce.ce_1p79;
			check_value("ce_6p & ce_6n", ce.ce_6p & ce.ce_6n, 0);
		end
		check_value("ce_12 count", n12, 28);
		check_value("ce_6p count", n6p, 14);
		check_value("ce_6n count", n6n, 14);
		check_value("ce_1p79 count", n1p79, 4);

		// Keyboard, scramble selected from reset
		send_key(9'h075, 1'b1);
		send_key(9'h02E, 1'b1);
		@(negedge clk_sys);
		check_value("ports.pa[0]", ports.pa[0], 0);
		check_value("ports.pa[7]", ports.pa[7], 0);
		send_key(9'h075, 1'b0);
		@(negedge clk_sys);
		check_value("ports.pa[0]", ports.pa[0], 1);
		check_value("ports.pa[7]", ports.pa[7], 0);
		send_key(9'h02E, 1'b0);
		@(negedge clk_sys);
		check_value("ports.pa", ports.pa, 8'hFF);

		check_game_cfg(scramble, hw_scramble, 0, 0);
		check_game_cfg(frogger,  hw_frogger,  0, 0);
		check_game_cfg(tazman,   hw_scobra,   0, 0);
		check_game_cfg(calipso,  hw_calipso,  0, 0);
		check_game_cfg(losttomb, hw_losttomb, 1, 0);
		check_game_cfg(minefld,  hw_losttomb, 1, 0);
		check_game_cfg(theend,   hw_scramble, 0, 1);

		// Port mapping table
		for (int i = 0; i < N_ENTRIES; i++)
		begin
			loader_write(IDX_GAME, 25'd0, tbl[i].game);
			joy1      = {5'($urandom), tbl[i].joy1};
			joy2      = {5'($urandom), tbl[i].joy2};
			fire_mode = tbl[i].fire_mode;
			@(negedge clk_sys);
			check_ports(tbl[i].ports);
			check_value("cfg", cfg, tbl[i].cfg);
		end

		// DIP masking with no input held
		joy1      = {5'($urandom), 11'h000};
		joy2      = {5'($urandom), 11'h000};
		fire_mode = 1'b0;
		loader_write(IDX_GAME, 25'd0, scramble);
		loader_write(IDX_DIPS, 25'd0, 8'h7F);
		check_ports(32'h7FFF_FFFF);
		loader_write(IDX_DIPS, 25'd9, 8'h00);  // Past the last bank
		check_ports(32'h7FFF_FFFF);

		// ROM strobe
		@(negedge clk_sys);
		ldr = '{wr: 1'b1, index: IDX_ROM, addr: 25'h0AB_CDE, data: 8'h5A};
		#(CLK_PERIOD / 4);
		check_value("rom_wr", rom_wr, 1);
		check_value("rom_addr", rom_addr, 16'hBCDE);
		check_value("rom_data", rom_data, 8'h5A);
		@(negedge clk_sys);
		ldr = '{wr: 1'b1, index: IDX_DIPS, addr: 25'd9, data: 8'h00};
		#(CLK_PERIOD / 4);
		check_value("rom_wr", rom_wr, 0);
		@(negedge clk_sys);
		ldr.wr = 1'b0;

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src/arcade_input_top.sv */
/*
 * Arcade input top
 * Control side of the Scramble-family wrapper: clock enables,
 * keyboard and joystick input, loader capture and port mapping
 */
`timescale 1ns/1ps
`default_nettype none

module arcade_input_top #(
	parameter int CE_SLOW_DIV = 14,
	parameter int DIP_BANKS   = 8
) (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  arcade_input_pkg::ps2_key_t    key,
	input  arcade_input_pkg::joy_t        joy1,
	input  arcade_input_pkg::joy_t        joy2,
	input  arcade_input_pkg::loader_wr_t  ldr,
	input  logic                          fire_mode,   // Alternate control layout
	output arcade_input_pkg::clk_en_t     ce,
	output arcade_input_pkg::port_bytes_t ports,
	output arcade_input_pkg::game_cfg_t   cfg,
	output logic                          rom_wr,
	output logic [15:0]                   rom_addr,
	output logic [7:0]                    rom_data
);

	import arcade_input_pkg::*;

	cab_buttons_t kbd;
	game_e        game;
	port_bytes_t  dips;

	clk_enable_gen #(
		.CE_SLOW_DIV (CE_SLOW_DIV)
	) u_clk_enable_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ce      (ce)
	);

	ps2_button_decoder u_ps2_button_decoder (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.key     (key),
		.kbd     (kbd)
	);

	loader_capture #(
		.DIP_BANKS (DIP_BANKS)
	) u_loader_capture (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.ldr      (ldr),
		.game     (game),
		.dips     (dips),
		.rom_wr   (rom_wr),
		.rom_addr (rom_addr),
		.rom_data (rom_data)
	);

	cabinet_input_map u_cabinet_input_map (
		.game      (game),
		.dips      (dips),
		.kbd       (kbd),
		.joy1      (joy1),
		.joy2      (joy2),
		.fire_mode (fire_mode),
		.ports     (ports),
		.cfg       (cfg)
	);

endmodule

`default_nettype wire

/* src/cabinet_input_map.sv */
/*
 * Cabinet input map
 * Merges keyboard and joysticks, then lays the controls out on the
 * four active-low port bytes and picks the board setup per game
 */
`timescale 1ns/1ps
`default_nettype none

module cabinet_input_map (
	input  arcade_input_pkg::game_e        game,
	input  arcade_input_pkg::port_bytes_t  dips,
	input  arcade_input_pkg::cab_buttons_t kbd,
	input  arcade_input_pkg::joy_t         joy1,
	input  arcade_input_pkg::joy_t         joy2,
	input  logic                           fire_mode,
	output arcade_input_pkg::port_bytes_t  ports,
	output arcade_input_pkg::game_cfg_t    cfg
);

	import arcade_input_pkg::*;

	// Joystick word into player controls
	function automatic player_ctrl_t joy_ctrl(input joy_t j);
		return '{up: j[3], down: j[2], left: j[1], right: j[0],
			fire_a: j[4], fire_b: j[5], fire_c: j[6], fire_d: j[7], fire_e: j[8]};
	endfunction

	player_ctrl_t p1, p2, m;
	joy_t         joy_any;
	logic         start1, start2, coin;
	port_bytes_t  lay;   // Active-high layout before inversion

	// ====================
	// Control merge
	// ====================

	assign p1      = kbd.p1 | joy_ctrl(joy1);
	assign p2      = kbd.p2 | joy_ctrl(joy2);
	assign m       = p1 | p2;
	assign joy_any = joy1 | joy2;
	assign start1  = kbd.start1 | joy_any[8];
	assign start2  = kbd.start2 | joy_any[9];
	assign coin    = kbd.coin | joy_any[10];

	// ====================
	// Port layout
	// ====================

	always_comb
	begin
		lay.pa = {coin, 1'b0, m.left, m.right, m.fire_a, 1'b0, m.fire_b, m.up};
		lay.pb = {start1, start2, m.left, m.right, m.fire_a, m.fire_b, 2'b00};
		lay.pc = {1'b0, m.down, 1'b0, m.up, 3'b000, m.down};
		lay.pd = 8'h00;

		case (game)
			tazman:
			begin
				lay.pa = {coin, 1'b0, m.left, m.right, m.down, m.up, m.fire_a, m.fire_b};
				lay.pb = 8'h00;
				lay.pc = {1'b0, start2, 5'b00000, start1};
			end
			calipso:
			begin
				lay.pa = {coin, 1'b0, m.left, m.right, m.down, m.up, 1'b0, start2 | m.fire_a};
				lay.pb = {2'b00, m.left, m.right, m.down, m.up, 2'b00};
				lay.pc = {7'b0000000, m.fire_a | start1};
			end
			losttomb:
			begin
				lay.pa = {coin, 1'b0, m.left, m.right, m.down, m.up, start1, start2};
				if (fire_mode)   // Move+fire layout
					lay.pb = {1'b0, m.fire_e | m.fire_a, m.left, m.right, m.down, m.up, 2'b00};
				else
					lay.pb = {1'b0, m.fire_e, m.fire_d, m.fire_a, m.fire_b, m.fire_c, 2'b00};
				lay.pc = 8'h00;
			end
			minefld:
			begin
				lay.pa = {coin, 1'b0, m.left, m.right, m.down, m.up, 1'b0, start1};
				if (fire_mode)
					lay.pb = {2'b00, m.left, m.right, m.down, m.up, 2'b00};
				else
					lay.pb = {2'b00, m.fire_d, m.fire_a, m.fire_b, m.fire_c, 2'b00};
				lay.pc = {1'b0, start2, 5'b00000, start1};
			end
			default: ;  // Scramble layout
		endcase
	end

	// Inverted, then masked by the DIP banks
	assign ports = ~lay & dips;

	// ====================
	// Board setup
	// ====================

	always_comb
	begin
		cfg = '{board: hw_scramble, landscape: 1'b0, fourfire: 1'b0, galaxian_video: 1'b0};

		case (game)
			frogger:  cfg.board = hw_frogger;
			tazman:   cfg.board = hw_scobra;
			calipso:  cfg.board = hw_calipso;
			losttomb,
			minefld:
			begin
				cfg.board    = hw_losttomb;
				cfg.fourfire = 1'b1;
			end
			theend:   cfg.galaxian_video = 1'b1;
			default: ;
		endcase
	end

	// Galaxian video only exists on the Scramble board wiring
	always_comb
		a_galaxian_board: assert #0 (!cfg.galaxian_video || (cfg.board == hw_scramble));

endmodule

`default_nettype wire

/* src/loader_capture.sv */
/*
 * Loader write capture
 * Holds the game select and the DIP-switch banks written by the
 * loader, and passes ROM writes on as a strobe
 */
`timescale 1ns/1ps
`default_nettype none

module loader_capture #(
	parameter int DIP_BANKS = 8
) (
	input  logic                          clk_sys,
	input  logic                          arst_n,
	input  arcade_input_pkg::loader_wr_t  ldr,
	output arcade_input_pkg::game_e       game,
	output arcade_input_pkg::port_bytes_t dips,
	output logic                          rom_wr,
	output logic [15:0]                   rom_addr,
	output logic [7:0]                    rom_data
);

	import arcade_input_pkg::*;

	localparam int AW = (DIP_BANKS > 2) ? $clog2(DIP_BANKS) : 1;

	logic [DIP_BANKS-1:0][7:0] dip_q;
	logic                      dip_hit;

	assign dip_hit = ldr.wr && (ldr.index == IDX_DIPS) && (ldr.addr < DIP_BANKS);

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			game  <= scramble;
			dip_q <= '1;   // All switches open
		end
		else
		begin
			if (ldr.wr && (ldr.index == IDX_GAME))
				game <= game_e'(ldr.data);
			if (dip_hit)
				dip_q[ldr.addr[AW-1:0]] <= ldr.data;
		end
	end

	// Only the first four banks reach the board ports
	assign dips = {dip_q[0], dip_q[1], dip_q[2], dip_q[3]};

	// ROM writes go straight through
	assign rom_wr   = ldr.wr && (ldr.index == IDX_ROM);
	assign rom_addr = ldr.addr[15:0];
	assign rom_data = ldr.data;

	a_hold_without_wr: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!ldr.wr |=> ($stable(game) && $stable(dip_q)));

endmodule

`default_nettype wire

/* src/ps2_button_decoder.sv */
/*
 * Keyboard button decoder
 * Turns scan-code events into held button levels for both players,
 * the start buttons and the coin slot
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_button_decoder (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	input  arcade_input_pkg::ps2_key_t     key,
	output arcade_input_pkg::cab_buttons_t kbd
);

	logic toggle_q;   // Toggle seen on the previous clock
	logic key_evt;

	assign key_evt = key.toggle != toggle_q;

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			toggle_q <= 1'b0;
			kbd      <= '0;
		end
		else
		begin
			toggle_q <= key.toggle;

			if (key_evt)
			begin
				case (key.code) inside
					// Cursor keys, extended prefix ignored
					9'b?_0111_0101: kbd.p1.up    <= key.pressed;
					9'b?_0111_0010: kbd.p1.down  <= key.pressed;
					9'b?_0110_1011: kbd.p1.left  <= key.pressed;
					9'b?_0111_0100: kbd.p1.right <= key.pressed;

					9'h014: kbd.p1.fire_a <= key.pressed;  // Ctrl
					9'h029: kbd.p1.fire_b <= key.pressed;  // Space

					// F1/F2 and the MAME style 1/2/5/6
					9'h005,
					9'h016: kbd.start1 <= key.pressed;
					9'h006,
					9'h01E: kbd.start2 <= key.pressed;
					9'h02E,
					9'h036: kbd.coin   <= key.pressed;

					// Player 2 on R F D G, fires on A and S
					9'h02D: kbd.p2.up     <= key.pressed;
					9'h02B: kbd.p2.down   <= key.pressed;
					9'h023: kbd.p2.left   <= key.pressed;
					9'h034: kbd.p2.right  <= key.pressed;
					9'h01C: kbd.p2.fire_a <= key.pressed;
					9'h01B: kbd.p2.fire_b <= key.pressed;

					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/clk_enable_gen.sv */
/*
 * Clock enable generator
 * Derives the 12 MHz, the two 6 MHz phases and the 1.79 MHz
 * enables from clk_sys
 */
`timescale 1ns/1ps
`default_nettype none

module clk_enable_gen #(
	parameter int CE_SLOW_DIV = 14
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	output arcade_input_pkg::clk_en_t ce
);

	localparam int CW = (CE_SLOW_DIV > 2) ? $clog2(CE_SLOW_DIV) : 1;

	logic [1:0]    div_q;   // Fast phase counter
	logic [CW-1:0] slow_q;  // Slow enable down-counter

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_q  <= 2'd0;
			slow_q <= CW'(CE_SLOW_DIV - 1);
			ce     <= '0;
		end
		else
		begin
			div_q      <= div_q + 2'd1;
			ce.ce_12   <= div_q[0];
			ce.ce_6p   <= div_q[0] & ~div_q[1];  // Lands on a ce_12 slot
			ce.ce_6n   <= div_q[0] & div_q[1];   // The other ce_12 slot

			if (slow_q == '0)
			begin
				slow_q     <= CW'(CE_SLOW_DIV - 1);
				ce.ce_1p79 <= 1'b1;
			end
			else
			begin
				slow_q     <= slow_q - 1'b1;
				ce.ce_1p79 <= 1'b0;
			end
		end
	end

	// The two 6 MHz phases interleave inside the 12 MHz pulses
	a_6_phases_apart: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ce.ce_6p && ce.ce_6n));

	a_6p_in_12: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce.ce_6p |-> ce.ce_12);

endmodule

`default_nettype wire

/* src/arcade_input_pkg.sv */
/*
 * Arcade input package
 * Game and board codes, control and port structs, and the loader
 * index values shared by the input blocks of the cabinet wrapper
 */
`default_nettype none

package arcade_input_pkg;

	// ====================
	// Codes
	// ====================

	// Game codes as sent by the loader, unknown values play as scramble
	typedef enum logic [7:0]
	{
		scramble = 8'd0,
		frogger  = 8'd2,
		tazman   = 8'd4,
		calipso  = 8'd8,
		losttomb = 8'd11,
		theend   = 8'd12,
		minefld  = 8'd16
	} game_e;

	typedef enum logic [7:0]
	{
		hw_scramble = 8'd0,
		hw_frogger  = 8'd1,
		hw_scobra   = 8'd2,
		hw_calipso  = 8'd3,
		hw_losttomb = 8'd7
	} hw_board_e;

	// Loader stream indices
	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_GAME = 8'd1;
	localparam logic [7:0] IDX_DIPS = 8'd254;

	// ====================
	// Structs
	// ====================

	typedef struct packed
	{
		logic       toggle;  // Flips on every key event
		logic       pressed;
		logic [8:0] code;    // Bit 8 is the extended prefix
	} ps2_key_t;

	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic fire_e;
	} player_ctrl_t;

	typedef struct packed
	{
		player_ctrl_t p1;
		player_ctrl_t p2;
		logic         start1;
		logic         start2;
		logic         coin;
	} cab_buttons_t;

	// R L D U in bits 0..3, fires a..e in 4..8, start1 shares 8
	typedef logic [15:0] joy_t;

	typedef struct packed
	{
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} loader_wr_t;

	// Active-low input port bytes of the board
	typedef struct packed
	{
		logic [7:0] pa;
		logic [7:0] pb;
		logic [7:0] pc;
		logic [7:0] pd;
	} port_bytes_t;

	typedef struct packed
	{
		hw_board_e board;
		logic      landscape;
		logic      fourfire;
		logic      galaxian_video;
	} game_cfg_t;

	typedef struct packed
	{
		logic ce_12;
		logic ce_6p;
		logic ce_6n;
		logic ce_1p79;
	} clk_en_t;

endpackage

`default_nettype wire
